//--- cdc_fifo.f
+incdir+include
src/cdc_fifo_pkg.sv
src/cdc_sync_flop.sv
src/cdc_fifo_mem.sv
src/cdc_fifo_ctrl.sv
src/cdc_fifo_rd_stage.sv
src/cdc_fifo.sv
verification/cdc_fifo_assertions.sv
verification/cdc_fifo_tb.sv

//--- Makefile
TOP := cdc_fifo_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f cdc_fifo.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

//--- verification/cdc_fifo_tb.sv
`timescale 1ns/1ps

module cdc_fifo_tb;

   localparam int DEPTH = cdc_fifo_pkg::DEPTH;
   // roughly 40 rclk cycles per test word, with a wide margin.
   localparam int TIMEOUT_CYCLES = 20000;

   logic                     wclk;
   logic                     rclk;
   logic                     wrst_n;
   logic                     rrst_n;
   logic                     in_valid;
   logic                     in_ready;
   logic                     out_valid;
   logic                     out_ready;
   cdc_fifo_pkg::fifo_word_t in_data;
   cdc_fifo_pkg::fifo_word_t out_data;
   cdc_fifo_pkg::slot_cnt_t  free_slots;
   cdc_fifo_pkg::slot_cnt_t  used_slots;

   cdc_fifo_pkg::fifo_word_t model_q [$];
   integer                   seed;
   int                       mismatch_count;
   int                       fail_count;
   int                       rclk_cycles;

   cdc_fifo #(
      .MODE (cdc_fifo_pkg::ASYNC)
   ) dut0 (
      .wclk       (wclk),
      .wrst_n     (wrst_n),
      .rclk       (rclk),
      .rrst_n     (rrst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_ready   (in_ready),
      .free_slots (free_slots),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .used_slots (used_slots)
   );

   always #50 rclk = ~rclk;
   always #35 wclk = ~wclk;

   always @(posedge rclk) begin
      rclk_cycles++;
      if (rclk_cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: test did not finish");
         $display("** FAIL **");
         $finish;
      end
   end

   // inputs change and outputs are sampled just after an edge.
   task automatic wait_wclk();
      @(posedge wclk);
      #5;
   endtask

   task automatic wait_rclk();
      @(posedge rclk);
      #5;
   endtask

   task automatic check_word(input cdc_fifo_pkg::fifo_word_t got,
                             input cdc_fifo_pkg::fifo_word_t exp, input string what);
      if (got !== exp) begin
         mismatch_count++;
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input cdc_fifo_pkg::slot_cnt_t got,
                              input cdc_fifo_pkg::slot_cnt_t exp, input string what);
      if (got !== exp) begin
         mismatch_count++;
         $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         mismatch_count++;
         $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // caller sits just after a wclk edge.
   task automatic push_word(input cdc_fifo_pkg::fifo_word_t data);
      bit accepted;
      accepted = 1'b0;
      in_valid = 1'b1;
      in_data  = data;
      while (!accepted) begin
         if (in_ready) begin
            accepted = 1'b1;
            model_q.push_back(data);
         end
         wait_wclk();
      end
      in_valid = 1'b0;
   endtask

   task automatic take_word();
      if (model_q.size() == 0) begin
         fail_count++;
         $display("output word %h appeared with nothing expected at %0t", out_data, $time);
      end
      else begin
         check_word(out_data, model_q.pop_front(), "output word");
      end
   endtask

   task automatic drain_words(input int n);
      int got;
      got = 0;
      wait_rclk();
      out_ready = 1'b1;
      while (got < n) begin
         if (out_valid) begin
            take_word();
            got++;
         end
         wait_rclk();
      end
      out_ready = 1'b0;
   endtask

   task automatic random_writer(input int n);
      int gap;
      wait_wclk();
      repeat (n) begin
         gap = $random(seed) & 3;
         repeat (gap) wait_wclk();
         push_word($random(seed));
      end
   endtask

   task automatic random_reader(input int n);
      int got;
      got = 0;
      wait_rclk();
      while (got < n) begin
         out_ready = ($random(seed) & 1) != 0;
         if (out_valid && out_ready) begin
            take_word();
            got++;
         end
         wait_rclk();
      end
      out_ready = 1'b0;
   endtask

   task automatic test_reset_state();
      repeat (5) wait_rclk();
      check_flag(out_valid, 1'b0, "out_valid after reset");
      check_count(used_slots, '0, "used_slots after reset");
      wait_wclk();
      check_flag(in_ready, 1'b1, "in_ready after reset");
      check_count(free_slots, cdc_fifo_pkg::slot_cnt_t'(DEPTH), "free_slots after reset");
   endtask

   task automatic test_in_order();
      fork
         begin
            wait_wclk();
            repeat (5) push_word($random(seed));
         end
         drain_words(5);
      join
   endtask

   task automatic test_capacity();
      int accepted;
      int stalled;
      accepted = 0;
      stalled  = 0;
      wait_wclk();
      in_valid = 1'b1;
      in_data  = $random(seed);
      // out_ready is low, so the output stage holds one word.
      while (stalled < 10) begin
         if (in_ready) begin
            model_q.push_back(in_data);
            accepted++;
            stalled = 0;
            wait_wclk();
            in_data = $random(seed);
         end
         else begin
            stalled++;
            wait_wclk();
         end
      end
      in_valid = 1'b0;
      check_count(cdc_fifo_pkg::slot_cnt_t'(accepted), cdc_fifo_pkg::slot_cnt_t'(DEPTH + 1),
                  "accepted words under back-pressure");
      drain_words(accepted);
   endtask

   task automatic test_streaming();
      fork
         random_writer(100);
         random_reader(100);
      join
   endtask

   task automatic test_counters();
      repeat (10) wait_rclk();
      repeat (10) wait_wclk();
      wait_rclk();
      check_count(used_slots, '0, "used_slots when drained");
      wait_wclk();
      check_count(free_slots, cdc_fifo_pkg::slot_cnt_t'(DEPTH), "free_slots when drained");
      repeat (DEPTH / 2) push_word($random(seed));
      repeat (10) wait_rclk();
      repeat (10) wait_wclk();
      wait_rclk();
      check_count(used_slots, cdc_fifo_pkg::slot_cnt_t'(DEPTH / 2 - 1), "used_slots parked");
      wait_wclk();
      check_count(free_slots, cdc_fifo_pkg::slot_cnt_t'(DEPTH - (DEPTH / 2 - 1)),
                  "free_slots parked");
      drain_words(DEPTH / 2);
   endtask

   initial begin
      wclk           = 1'b0;
      rclk           = 1'b0;
      wrst_n         = 1'b0;
      rrst_n         = 1'b0;
      in_valid       = 1'b0;
      in_data        = '0;
      out_ready      = 1'b0;
      seed           = 32'he10ae996;
      mismatch_count = 0;
      fail_count     = 0;
      rclk_cycles    = 0;

      repeat (10) @(posedge rclk);
      #5;
      wrst_n = 1'b1;
      rrst_n = 1'b1;

      test_reset_state();
      test_in_order();
      test_capacity();
      test_streaming();
      test_counters();

      if (model_q.size() != 0) begin
         fail_count++;
         $display("%0d words were written but never came out", model_q.size());
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("** PASS **");
      end
      else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- verification/cdc_fifo_assertions.sv
`timescale 1ns/1ps

module cdc_fifo_ctrl_assertions #(
   parameter cdc_fifo_pkg::fifo_mode_e MODE = cdc_fifo_pkg::ASYNC
) (
   input logic                        wclk,
   input logic                        wrst_n,
   input logic                        rclk,
   input logic                        rrst_n,
   input logic                        full,
   input logic                        empty,
   input logic [cdc_fifo_pkg::PTR_W:0] wptr_q,
   input logic [cdc_fifo_pkg::PTR_W:0] rptr_q
);

   wptr_hold: assert property (@(posedge wclk) disable iff (!wrst_n) full |=> $stable(wptr_q))
      else $error("write pointer moved while full");

   rptr_hold: assert property (@(posedge rclk) disable iff (!rrst_n) empty |=> $stable(rptr_q))
      else $error("read pointer moved while empty");

   if (MODE == cdc_fifo_pkg::ASYNC) begin : g_gray
      // one bit per step keeps the far side sample coherent.
      wgray_step: assert property (@(posedge wclk) disable iff (!wrst_n)
         $onehot0(wptr_q ^ $past(wptr_q)))
         else $error("write Gray pointer changed more than one bit");

      rgray_step: assert property (@(posedge rclk) disable iff (!rrst_n)
         $onehot0(rptr_q ^ $past(rptr_q)))
         else $error("read Gray pointer changed more than one bit");
   end

   full_after_reset: assert property (@(posedge wclk) $rose(wrst_n) |-> !full)
      else $error("full set in first cycle after reset");

   // read side starts out empty.
   empty_after_reset: assert property (@(posedge rclk) $rose(rrst_n) |-> empty)
      else $error("empty clear in first cycle after reset");

endmodule

bind cdc_fifo_ctrl cdc_fifo_ctrl_assertions #(
   .MODE (MODE)
) ctrl_assertions_u (
   .wclk   (wclk),
   .wrst_n (wrst_n),
   .rclk   (rclk),
   .rrst_n (rrst_n),
   .full   (full),
   .empty  (empty),
   .wptr_q (wptr_q),
   .rptr_q (rptr_q)
);

//--- src/cdc_fifo.sv
`timescale 1ns/1ps

module cdc_fifo #(
   parameter cdc_fifo_pkg::fifo_mode_e MODE = cdc_fifo_pkg::ASYNC
) (
   input  logic                    wclk,
   input  logic                    wrst_n,
   input  logic                    rclk,
   input  logic                    rrst_n,

   // write interface, wclk domain.
   input  logic                    in_valid,
   input  cdc_fifo_pkg::fifo_word_t in_data,
   output logic                    in_ready,
   output cdc_fifo_pkg::slot_cnt_t free_slots,

   // read interface, rclk domain.
   output logic                    out_valid,
   input  logic                    out_ready,
   output cdc_fifo_pkg::fifo_word_t out_data,
   output cdc_fifo_pkg::slot_cnt_t used_slots
);

   logic                           push;
   logic                           pop;
   logic                           full;
   logic                           empty;
   logic [cdc_fifo_pkg::PTR_W-1:0] wptr;
   logic [cdc_fifo_pkg::PTR_W-1:0] rptr;
   cdc_fifo_pkg::fifo_word_t       rd_data;

   assign in_ready = !full;
   assign push     = in_valid && in_ready;

   cdc_fifo_ctrl #(
      .MODE (MODE)
   ) ctrl_u (
      .wclk       (wclk),
      .wrst_n     (wrst_n),
      .rclk       (rclk),
      .rrst_n     (rrst_n),
      .push       (push),
      .full       (full),
      .free_slots (free_slots),
      .wptr       (wptr),
      .pop        (pop),
      .empty      (empty),
      .used_slots (used_slots),
      .rptr       (rptr)
   );

   cdc_fifo_mem #(
      .payload_t (cdc_fifo_pkg::fifo_word_t)
   ) mem_u (
      .wclk  (wclk),
      .we    (push),
      .waddr (wptr),
      .wdata (in_data),
      .raddr (rptr),
      .rdata (rd_data)
   );

   cdc_fifo_rd_stage #(
      .payload_t (cdc_fifo_pkg::fifo_word_t)
   ) rd_stage_u (
      .rclk      (rclk),
      .rrst_n    (rrst_n),
      .empty     (empty),
      .pop       (pop),
      .rd_data   (rd_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

endmodule

//--- src/cdc_fifo_rd_stage.sv
`timescale 1ns/1ps

module cdc_fifo_rd_stage #(
   parameter type payload_t = cdc_fifo_pkg::fifo_word_t
) (
   input  logic     rclk,
   input  logic     rrst_n,

   // controller and memory side.
   input  logic     empty,
   output logic     pop,
   input  payload_t rd_data,

   // consumer side.
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic slot_free;

   // register is free, or drains this edge.
   assign slot_free = !out_valid || out_ready;

   assign pop = !empty && slot_free;

   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         out_valid <= 1'b0;
      end
      else if (pop) begin
         out_valid <= 1'b1;
      end
      else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // held while the consumer stalls.
   always_ff @(posedge rclk) begin
      if (pop) begin
         out_data <= rd_data;
      end
   end

endmodule

//--- src/cdc_fifo_ctrl.sv
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_ctrl #(
   parameter cdc_fifo_pkg::fifo_mode_e MODE = cdc_fifo_pkg::ASYNC
) (
   input  logic                                      wclk,
   input  logic                                      wrst_n,
   input  logic                                      rclk,
   input  logic                                      rrst_n,

   // write domain.
   input  logic                                      push,
   output logic                                      full,
   output cdc_fifo_pkg::slot_cnt_t                   free_slots,
   output logic [`CDC_LOG_VEC(cdc_fifo_pkg::DEPTH)]  wptr,

   // read domain.
   input  logic                                      pop,
   output logic                                      empty,
   output cdc_fifo_pkg::slot_cnt_t                   used_slots,
   output logic [`CDC_LOG_VEC(cdc_fifo_pkg::DEPTH)]  rptr
);

   localparam int DEPTH = cdc_fifo_pkg::DEPTH;
   localparam int PTR_W = cdc_fifo_pkg::PTR_W;
   localparam int RANKS = (MODE == cdc_fifo_pkg::ASYNC) ? cdc_fifo_pkg::SYNC_RANKS : 0;

   // one extra bit tells full from empty.
   typedef logic [`CDC_VEC(PTR_W + 1)] ptr_t;

   localparam ptr_t MSB_FLIP = {1'b1, {PTR_W{1'b0}}};

   if ((MODE == cdc_fifo_pkg::ASYNC) && ((1 << PTR_W) != DEPTH)) begin : g_depth_check
      $fatal(1, "cdc_fifo_ctrl: ASYNC mode needs a power of two DEPTH");
   end

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[PTR_W] = g[PTR_W];
      for (int i = PTR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // what the pointer register holds and what crosses the boundary.
   function automatic ptr_t to_wire(input ptr_t b);
      return (MODE == cdc_fifo_pkg::ASYNC) ? bin2gray(b) : b;
   endfunction

   function automatic ptr_t from_wire(input ptr_t p);
      return (MODE == cdc_fifo_pkg::ASYNC) ? gray2bin(p) : p;
   endfunction

   // wrap at DEPTH-1 and flip the lap bit.
   function automatic ptr_t ptr_next(input ptr_t b);
      if (b[PTR_W-1:0] == PTR_W'(DEPTH - 1)) begin
         return {~b[PTR_W], {PTR_W{1'b0}}};
      end
      return b + 1'b1;
   endfunction

   // linear position 0..2*DEPTH-1.
   function automatic int unsigned ptr_val(input ptr_t p);
      return int'(p[PTR_W-1:0]) + (p[PTR_W] ? DEPTH : 0);
   endfunction

   // words between two pointers, 0..DEPTH.
   function automatic cdc_fifo_pkg::slot_cnt_t ptr_dist(input ptr_t ahead, input ptr_t behind);
      int unsigned a;
      int unsigned b;
      a = ptr_val(ahead);
      b = ptr_val(behind);
      if (a < b) begin
         a += 2 * DEPTH;
      end
      return cdc_fifo_pkg::slot_cnt_t'(a - b);
   endfunction

   ptr_t wptr_q;
   ptr_t rptr_q;
   ptr_t wptr_sync;
   ptr_t rptr_sync;
   ptr_t w_bin;
   ptr_t r_bin;
   ptr_t wsync_bin;
   ptr_t rsync_bin;

   // read pointer into the write domain.
   cdc_sync_flop #(
      .WIDTH (PTR_W + 1),
      .RANKS (RANKS)
   ) rptr_sync_u (
      .clk   (wclk),
      .rst_n (wrst_n),
      .din   (rptr_q),
      .dout  (rptr_sync)
   );

   // write pointer into the read domain.
   cdc_sync_flop #(
      .WIDTH (PTR_W + 1),
      .RANKS (RANKS)
   ) wptr_sync_u (
      .clk   (rclk),
      .rst_n (rrst_n),
      .din   (wptr_q),
      .dout  (wptr_sync)
   );

   // write side.
   assign w_bin      = from_wire(wptr_q);
   assign rsync_bin  = from_wire(rptr_sync);
   assign wptr       = w_bin[PTR_W-1:0];
   assign full       = (rsync_bin == (w_bin ^ MSB_FLIP));
   assign free_slots = cdc_fifo_pkg::slot_cnt_t'(DEPTH) - ptr_dist(w_bin, rsync_bin);

   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         wptr_q <= '0;
      end
      else if (push && !full) begin
         wptr_q <= to_wire(ptr_next(w_bin));
      end
   end

   // read side.
   assign r_bin      = from_wire(rptr_q);
   assign wsync_bin  = from_wire(wptr_sync);
   assign rptr       = r_bin[PTR_W-1:0];
   assign empty      = (wsync_bin == r_bin);
   assign used_slots = ptr_dist(wsync_bin, r_bin);

   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         rptr_q <= '0;
      end
      else if (pop && !empty) begin
         rptr_q <= to_wire(ptr_next(r_bin));
      end
   end

endmodule

//--- src/cdc_fifo_mem.sv
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_mem #(
   parameter type payload_t = cdc_fifo_pkg::fifo_word_t
) (
   // write side, wclk domain.
   input  logic                               wclk,
   input  logic                               we,
   input  logic [`CDC_VEC(cdc_fifo_pkg::PTR_W)] waddr,
   input  payload_t                           wdata,

   // read side, no clock.
   input  logic [`CDC_VEC(cdc_fifo_pkg::PTR_W)] raddr,
   output payload_t                           rdata
);

   payload_t mem_q [cdc_fifo_pkg::DEPTH];

   always_ff @(posedge wclk) begin
      if (we) begin
         mem_q[waddr] <= wdata;
      end
   end

   // an entry is only read once the synchronized write pointer has
   // moved past it, so the word is stable by then.
   assign rdata = mem_q[raddr];

endmodule

//--- src/cdc_sync_flop.sv
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_sync_flop #(
   parameter int WIDTH = 1,
   parameter int RANKS = 2
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [`CDC_VEC(WIDTH)] din,
   output logic [`CDC_VEC(WIDTH)] dout
);

   if (RANKS == 0) begin : g_pass
      // same clock on both sides.
      assign dout = din;
   end
   else begin : g_ranks
      logic [`CDC_VEC(WIDTH)] stage_q [RANKS];

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            for (int i = 0; i < RANKS; i++) begin
               stage_q[i] <= '0;
            end
         end
         else begin
            stage_q[0] <= din;
            for (int i = 1; i < RANKS; i++) begin
               stage_q[i] <= stage_q[i-1];
            end
         end
      end

      assign dout = stage_q[RANKS-1];
   end

endmodule

//--- src/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

   // pointer crossing mode.
   // ASYNC means Gray pointers and synchronizer ranks; SYNC means one shared clock.
   typedef enum logic {
      SYNC  = 1'b0,
      ASYNC = 1'b1
   } fifo_mode_e;

   // number of storage entries.
   localparam int DEPTH = 8;

   // payload width.
   localparam int DATA_W = 32;

   // memory address width.
   localparam int PTR_W = $clog2(DEPTH);

   // slot counters run 0..DEPTH inclusive.
   localparam int CNT_W = $clog2(DEPTH + 1);

   // ranks per direction in ASYNC mode.
   localparam int SYNC_RANKS = 2;

   // top level payload.
   typedef logic [DATA_W-1:0] fifo_word_t;

   // free and used slot counts.
   typedef logic [CNT_W-1:0] slot_cnt_t;

endpackage

//--- include/cdc_fifo_defs.svh
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// packed range for a vector of w bits.
`define CDC_VEC(w) ((w)-1):0

// packed range wide enough to hold n distinct values.
`define CDC_LOG_VEC(n) ($clog2(n)-1):0

`endif
